//--- build.f
+incdir+verilog
verilog/bpred_pkg.sv
verilog/insn_mem.sv
verilog/perceptron_dir.sv
verilog/branch_target.sv
verilog/next_pc_select.sv
verilog/bpred_top.sv
bench/bpred_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = bpred_tb
FILELIST = build.f
PASS_MSG = All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- bench/bpred_tb.sv
`timescale 1ns/100ps
`include "bpred_params.svh"

module bpred_tb;
	import bpred_pkg::*;

	localparam int run_len = 300;
	localparam int max_cycles = 20000;
	localparam int words = 1 << `BPRED_IMEM_AW;
	localparam int entries = 1 << `BPRED_TBL_AW;
	localparam int hlen = `BPRED_GHR_LEN;

	logic		clk;
	logic		reset;
	logic		imem_we;
	imem_addr_t	imem_waddr;
	insn_t		imem_wdata;
	logic		redirect;
	addr_t		redirect_pc;
	logic		stall;
	logic		update;
	addr_t		update_pc;
	logic		update_dir;
	addr_t		fetch_pc;
	insn_t		fetch_insn;
	logic		fetch_taken;

	// ============================================================
	// reference model state
	// ============================================================
	insn_t		m_mem [0:words-1];
	int			m_w [0:entries-1][0:hlen-1];
	// registered lookup one cycle behind next pc
	int			m_lu_w [0:hlen-1];
	ghr_t		m_ghr;
	addr_t		m_stack [0:`BPRED_RAS_DEPTH-1];
	ras_ptr_t	m_ptr;
	addr_t		m_pc;
	insn_t		m_insn;

	int			err_count;
	int			fail_tests;
	int			test_count;
	// off while fetch_insn may still be unloaded
	bit			taken_check_en;

	bpred_top u_dut (
		.clk			(clk),
		.reset			(reset),
		.imem_we		(imem_we),
		.imem_waddr		(imem_waddr),
		.imem_wdata		(imem_wdata),
		.redirect		(redirect),
		.redirect_pc	(redirect_pc),
		.stall			(stall),
		.update			(update),
		.update_pc		(update_pc),
		.update_dir		(update_dir),
		.fetch_pc		(fetch_pc),
		.fetch_insn		(fetch_insn),
		.fetch_taken	(fetch_taken)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// watchdog bounds the whole run
	initial begin
		for (int n = 0; n < max_cycles; n++) begin
			@(posedge clk);
		end
		$display("timeout: simulation ran past %0d cycles", max_cycles);
		$display("Test failures found");
		$finish;
	end

	// ============================================================
	// model functions
	// ============================================================
	// +w for taken history bits and -w otherwise
	function automatic logic model_perc();
		int sum;
		sum = 0;
		for (int i = 0; i < hlen; i++) begin
			if (m_ghr[i])
				sum = sum + m_lu_w[i];
			else
				sum = sum - m_lu_w[i];
		end
		return sum >= 0;
	endfunction

	function automatic logic model_taken();
		return m_insn[29] | model_perc();
	endfunction

	function automatic logic [1:0] model_src();
		if (model_taken() === 1'b1)
			return m_insn[31:30];
		return 2'b00;
	endfunction

	function automatic addr_t model_next(logic redir, addr_t rpc);
		addr_t pc4;
		addr_t off;
		addr_t res;
		pc4 = m_pc + 32'd4;
		off = {{16{m_insn[15]}}, m_insn[15:0]};
		case (model_src())
			2'b00: res = pc4;
			2'b01: res = m_stack[ras_ptr_t'(m_ptr - 1'b1)];
			2'b10: res = (pc4 + off) & ~32'h3;
			default: res = {m_pc[31:28], m_insn[25:0], 2'b00};
		endcase
		if (redir)
			res = rpc;
		return res;
	endfunction

	// one clock of the model with the inputs now applied
	task automatic model_advance();
		addr_t	nxt;
		addr_t	pc4;
		logic	push;
		logic	pop;
		int		li;
		int		ui;
		pc4 = m_pc + 32'd4;
		nxt = model_next(redirect, redirect_pc);
		push = m_insn[27] & ~redirect;
		pop = (model_src() == 2'b01) & ~redirect;
		// lookup sees weights from before this edge
		li = nxt[7:2];
		for (int i = 0; i < hlen; i++)
			m_lu_w[i] = m_w[li][i];
		// training on pre-shift history
		if (update && !stall) begin
			ui = update_pc[7:2];
			for (int i = 0; i < hlen; i++) begin
				if (update_dir == m_ghr[i]) begin
					if (m_w[ui][i] < 127)
						m_w[ui][i] = m_w[ui][i] + 1;
				end else if (m_w[ui][i] > -127) begin
					m_w[ui][i] = m_w[ui][i] - 1;
				end
			end
		end
		if (update)
			m_ghr = {m_ghr[hlen-2:0], update_dir};
		// replace, push or pop
		if (push && pop) begin
			m_stack[ras_ptr_t'(m_ptr - 1'b1)] = pc4;
		end else if (push) begin
			m_stack[m_ptr] = pc4;
			m_ptr = ras_ptr_t'(m_ptr + 1'b1);
		end else if (pop) begin
			m_ptr = ras_ptr_t'(m_ptr - 1'b1);
		end
		// old word on a same-address write
		m_insn = m_mem[nxt[9:2]];
		if (imem_we)
			m_mem[imem_waddr] = imem_wdata;
		m_pc = nxt;
	endtask

	// ============================================================
	// stimulus and checks
	// ============================================================
	task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic step(logic we, imem_addr_t wa, insn_t wd, logic redir, addr_t rpc,
		logic upd, addr_t upc, logic udir, logic stl);
		@(posedge clk);
		imem_we <= we;
		imem_waddr <= wa;
		imem_wdata <= wd;
		redirect <= redir;
		redirect_pc <= rpc;
		update <= upd;
		update_pc <= upc;
		update_dir <= udir;
		stall <= stl;
		// outputs settled well away from the edge
		@(negedge clk);
		check_val("fetch_pc", fetch_pc, m_pc);
		check_val("fetch_insn", fetch_insn, m_insn);
		if (taken_check_en)
			check_val("fetch_taken", fetch_taken, model_taken());
		model_advance();
	endtask

	function automatic insn_t mk_word(logic [1:0] src, logic unc, logic call, logic [25:0] imm);
		return {src, unc, 1'b0, call, 1'b0, imm};
	endfunction

	// short signed word offset for the 16-bit field
	function automatic logic [15:0] rel_imm();
		logic [7:0] r;
		r = 8'($urandom);
		return {{6{r[7]}}, r, 2'b00};
	endfunction

	// one program style per test
	function automatic insn_t gen_word(int kind, int a);
		int r;
		r = $urandom % 10;
		case (kind)
			0: return '0;
			1: begin
				if (r < 3)
					return '0;
				else if (r < 6)
					return mk_word(2'b10, 1'b1, 1'b0, {10'd0, rel_imm()});
				else if (r < 8)
					return mk_word(2'b11, 1'b1, 1'b0, 26'($urandom));
				return mk_word(2'b10, 1'b1, 1'b1, {10'd0, rel_imm()});
			end
			2: begin
				if (r < 5)
					return mk_word(2'b10, 1'b1, 1'b0, 26'($urandom));
				return mk_word(2'b11, 1'b1, 1'b0, 26'($urandom));
			end
			3: begin
				// first 8 words fill every stack slot
				if (a < 8)
					return mk_word(2'b10, 1'b1, 1'b1, 26'd0);
				if (r < 3)
					return mk_word(2'b10, 1'b1, 1'b1, {10'd0, rel_imm()});
				else if (r < 4)
					return mk_word(2'b11, 1'b1, 1'b1, 26'($urandom));
				else if (r < 7)
					return mk_word(2'b01, 1'b1, 1'b0, 26'd0);
				return '0;
			end
			default: begin
				// conditional with the direction from the perceptron
				if (r < 6)
					return mk_word(2'b10, 1'b0, 1'b0, {10'd0, rel_imm()});
				return '0;
			end
		endcase
	endfunction

	// fetch parked at 0 by redirect while the memory fills
	task automatic load_mem(int kind);
		taken_check_en = 0;
		for (int a = 0; a < words; a++)
			step(1'b1, imem_addr_t'(a), gen_word(kind, a), 1'b1, '0, 1'b0, '0, 1'b0, 1'b0);
		step(1'b0, '0, '0, 1'b1, '0, 1'b0, '0, 1'b0, 1'b0);
		taken_check_en = 1;
	endtask

	task automatic report_test(string name, int start);
		test_count++;
		if (err_count == start) begin
			$display("test %s: PASS", name);
		end else begin
			fail_tests++;
			$display("test %s: FAIL, %0d errors", name, err_count - start);
		end
	endtask

	// conditional run with training and optional stall
	task automatic train_run(logic use_stall);
		logic	upd;
		addr_t	upc;
		for (int n = 0; n < run_len; n++) begin
			upd = 1'($urandom);
			// half the updates hit the entry looked up this cycle
			if ($urandom % 2)
				upc = model_next(1'b0, '0);
			else
				upc = $urandom & ~32'h3;
			step(1'b0, '0, '0, 1'b0, '0, upd, upc, 1'($urandom), use_stall & 1'($urandom));
		end
	endtask

	// ============================================================
	// main sequence
	// ============================================================
	initial begin
		int		start;
		logic	redir;
		logic	pend;
		addr_t	rpc;
		addr_t	pend_pc;
		void'($urandom(32'h59784283));
		err_count = 0;
		fail_tests = 0;
		test_count = 0;
		taken_check_en = 0;
		reset = 1'b1;
		imem_we = 1'b0;
		imem_waddr = '0;
		imem_wdata = '0;
		redirect = 1'b1;
		redirect_pc = '0;
		stall = 1'b0;
		update = 1'b0;
		update_pc = '0;
		update_dir = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		// cleared state in the first cycle out of reset
		m_pc = '0;
		m_ghr = '0;
		m_ptr = '0;
		m_insn = 'x;
		for (int e = 0; e < entries; e++)
			for (int i = 0; i < hlen; i++)
				m_w[e][i] = 0;
		for (int i = 0; i < hlen; i++)
			m_lu_w[i] = 0;
		start = err_count;
		check_val("fetch_pc", fetch_pc, 32'd0);
		model_advance();
		report_test("reset", start);

		start = err_count;
		load_mem(0);
		for (int n = 0; n < run_len; n++) begin
			step(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
			check_val("fetch_pc", fetch_pc, 32'(4 * n));
		end
		report_test("sequential", start);

		start = err_count;
		load_mem(1);
		pend = 1'b0;
		pend_pc = '0;
		for (int n = 0; n < run_len; n++) begin
			redir = ($urandom % 3) == 0;
			rpc = $urandom & ~32'h3;
			step(1'b0, '0, '0, redir, rpc, 1'b0, '0, 1'b0, 1'b0);
			if (pend)
				check_val("fetch_pc", fetch_pc, pend_pc);
			pend = redir;
			pend_pc = rpc;
		end
		report_test("redirect", start);

		start = err_count;
		load_mem(2);
		for (int n = 0; n < run_len; n++) begin
			step(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
			check_val("fetch_taken", fetch_taken, 32'd1);
		end
		report_test("unconditional", start);

		start = err_count;
		load_mem(3);
		for (int n = 0; n < run_len; n++)
			step(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
		report_test("call_return", start);

		start = err_count;
		load_mem(4);
		train_run(1'b0);
		report_test("perceptron_train", start);

		start = err_count;
		load_mem(4);
		train_run(1'b1);
		report_test("stall_train", start);

		$display("tests run %0d, failed %0d, check errors %0d", test_count, fail_tests,
			err_count);
		if (fail_tests == 0 && err_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- verilog/bpred_top.sv
`timescale 1ns/100ps

module bpred_top (
	input	logic					clk,
	input	logic					reset,
	// insn memory load
	input	logic					imem_we,
	input	bpred_pkg::imem_addr_t	imem_waddr,
	input	bpred_pkg::insn_t		imem_wdata,
	// redirect from later stages
	input	logic					redirect,
	input	bpred_pkg::addr_t		redirect_pc,
	input	logic					stall,
	// resolved branches from execute
	input	logic					update,
	input	bpred_pkg::addr_t		update_pc,
	input	logic					update_dir,
	// fetch side
	output	bpred_pkg::addr_t		fetch_pc,
	output	bpred_pkg::insn_t		fetch_insn,
	output	logic					fetch_taken
);
	import bpred_pkg::*;

	addr_t	next_pc;
	addr_t	ras_top;
	addr_t	tgt_imm16;
	addr_t	tgt_imm26;
	logic	perc_taken;
	logic	ras_push;
	logic	ras_pop;

	// ============================================================
	// both memories read at next_pc, results line up with fetch_pc
	// ============================================================
	insn_mem u_insn_mem (
		.clk		(clk),
		.we			(imem_we),
		.waddr		(imem_waddr),
		.wdata		(imem_wdata),
		.raddr		(next_pc),
		.rdata		(fetch_insn)
	);

	perceptron_dir u_perceptron_dir (
		.clk		(clk),
		.reset		(reset),
		.lookup_pc	(next_pc),
		.update		(update),
		.update_pc	(update_pc),
		.update_dir	(update_dir),
		.stall		(stall),
		.perc_taken	(perc_taken)
	);

	// targets for the word now at fetch_pc
	branch_target u_branch_target (
		.clk		(clk),
		.reset		(reset),
		.fetch_pc	(fetch_pc),
		.fetch_insn	(fetch_insn),
		.ras_push	(ras_push),
		.ras_pop	(ras_pop),
		.ras_top	(ras_top),
		.tgt_imm16	(tgt_imm16),
		.tgt_imm26	(tgt_imm26)
	);

	next_pc_select u_next_pc_select (
		.clk			(clk),
		.reset			(reset),
		.fetch_insn		(fetch_insn),
		.perc_taken		(perc_taken),
		.ras_top		(ras_top),
		.tgt_imm16		(tgt_imm16),
		.tgt_imm26		(tgt_imm26),
		.redirect		(redirect),
		.redirect_pc	(redirect_pc),
		.next_pc		(next_pc),
		.fetch_pc		(fetch_pc),
		.fetch_taken	(fetch_taken),
		.ras_push		(ras_push),
		.ras_pop		(ras_pop)
	);

endmodule

//--- verilog/next_pc_select.sv
`timescale 1ns/100ps
`include "bpred_params.svh"

module next_pc_select (
	input	logic				clk,
	input	logic				reset,
	input	bpred_pkg::insn_t	fetch_insn,
	input	logic				perc_taken,
	input	bpred_pkg::addr_t	ras_top,
	input	bpred_pkg::addr_t	tgt_imm16,
	input	bpred_pkg::addr_t	tgt_imm26,
	input	logic				redirect,
	input	bpred_pkg::addr_t	redirect_pc,
	output	bpred_pkg::addr_t	next_pc,
	output	bpred_pkg::addr_t	fetch_pc,
	output	logic				fetch_taken,
	output	logic				ras_push,
	output	logic				ras_pop
);
	import bpred_pkg::*;

	addr_t		pc4;
	tgt_src_t	pd_src;
	tgt_src_t	src;
	logic		uncond;
	logic		call;
	logic		taken;

	assign pc4 = fetch_pc + addr_t'(4);

	// predecode bits of the word at fetch_pc
	assign pd_src = tgt_src_t'(fetch_insn[`BPRED_F_SRC]);
	assign uncond = fetch_insn[`BPRED_F_UNCOND];
	assign call = fetch_insn[`BPRED_F_CALL];

	// ============================================================
	// direction and source
	// ============================================================
	assign taken = uncond | perc_taken;
	// not taken always falls through
	assign src = taken ? pd_src : src_seq;
	// redirect does not mask the reported prediction
	assign fetch_taken = taken;

	// stack only moves on a path that is really followed
	assign ras_push = call & ~redirect;
	assign ras_pop = (src == src_ras) & ~redirect;

	// redirect beats every prediction
	// reset parks the fetch at address 0
	always_comb begin
		if (reset) begin
			next_pc = '0;
		end else if (redirect) begin
			next_pc = redirect_pc;
		end else begin
			case (src)
				src_seq:	next_pc = pc4;
				src_ras:	next_pc = ras_top;
				src_imm16:	next_pc = tgt_imm16;
				src_imm26:	next_pc = tgt_imm26;
				default:	next_pc = pc4;
			endcase
		end
	end

	// one fetch every cycle with no back-pressure
	always_ff @(posedge clk) begin
		fetch_pc <= next_pc;
	end

	// a return needs an address that some call has pushed
	a_pop_has_target: assert property (@(posedge clk) disable iff (reset)
		ras_pop |-> !$isunknown(ras_top));

endmodule

//--- verilog/branch_target.sv
`timescale 1ns/100ps
`include "bpred_params.svh"

module branch_target (
	input	logic				clk,
	input	logic				reset,
	input	bpred_pkg::addr_t	fetch_pc,
	input	bpred_pkg::insn_t	fetch_insn,
	input	logic				ras_push,
	input	logic				ras_pop,
	output	bpred_pkg::addr_t	ras_top,
	output	bpred_pkg::addr_t	tgt_imm16,
	output	bpred_pkg::addr_t	tgt_imm26
);
	import bpred_pkg::*;

	// return addresses, pointer marks the next free slot
	addr_t		stack [0:`BPRED_RAS_DEPTH-1];
	ras_ptr_t	ptr;
	ras_ptr_t	ptr_below;
	addr_t		pc4;
	addr_t		imm16_sext;
	addr_t		imm16_sum;

	assign pc4 = fetch_pc + addr_t'(4);

	// ============================================================
	// return address stack
	// ============================================================
	// entry under the pointer, wraps at zero
	assign ptr_below = ras_ptr_t'(ptr - 1'b1);
	assign ras_top = stack[ptr_below];

	// push and pop together replace the top in place
	always_ff @(posedge clk) begin
		if (ras_push && ras_pop) begin
			stack[ptr_below] <= pc4;
		end else if (ras_push) begin
			stack[ptr] <= pc4;
		end
	end

	// pointer wraps, oldest entries get overwritten
	always_ff @(posedge clk) begin
		if (reset) begin
			ptr <= '0;
		end else if (ras_push && !ras_pop) begin
			ptr <= ras_ptr_t'(ptr + 1'b1);
		end else if (ras_pop && !ras_push) begin
			ptr <= ptr_below;
		end
	end

	// ============================================================
	// immediate targets
	// ============================================================
	// pc-relative, offset from pc+4
	assign imm16_sext = {{(`BPRED_ADDR_W-16){fetch_insn[`BPRED_F_IMM16_SIGN]}},
		fetch_insn[`BPRED_F_IMM16]};
	assign imm16_sum = pc4 + imm16_sext;
	// low bits dropped, targets stay word aligned
	assign tgt_imm16 = {imm16_sum[`BPRED_ADDR_W-1:2], 2'b00};

	// region-absolute, keeps the 256MB region of fetch_pc
	assign tgt_imm26 = {fetch_pc[`BPRED_ADDR_W-1:`BPRED_ADDR_W-4],
		fetch_insn[`BPRED_F_IMM26], 2'b00};

endmodule

//--- verilog/perceptron_dir.sv
`timescale 1ns/100ps
`include "bpred_params.svh"

module perceptron_dir (
	input	logic				clk,
	input	logic				reset,
	input	bpred_pkg::addr_t	lookup_pc,
	input	logic				update,
	input	bpred_pkg::addr_t	update_pc,
	input	logic				update_dir,
	input	logic				stall,
	output	logic				perc_taken
);
	import bpred_pkg::*;

	// 64 entries of 8 weights, flops so reset can clear them
	weight_t	tbl [0:(1 << `BPRED_TBL_AW)-1][0:`BPRED_GHR_LEN-1];
	// weights of the entry at last cycle's lookup_pc
	weight_t	lu_w [0:`BPRED_GHR_LEN-1];
	// trained copy of the entry at update_pc
	weight_t	up_w [0:`BPRED_GHR_LEN-1];
	ghr_t		ghr;
	tbl_idx_t	lu_idx;
	tbl_idx_t	up_idx;
	psum_t		psum;
	logic		up_wen;

	// pc[7:2] for both ports
	assign lu_idx = lookup_pc[`BPRED_TBL_AW+1:2];
	assign up_idx = update_pc[`BPRED_TBL_AW+1:2];
	// stall only holds back table writes
	assign up_wen = update & ~stall;

	// ============================================================
	// global history
	// ============================================================
	// shifts on every update, stalled or not
	always_ff @(posedge clk) begin
		if (reset) begin
			ghr <= '0;
		end else if (update) begin
			ghr <= {ghr[`BPRED_GHR_LEN-2:0], update_dir};
		end
	end

	// ============================================================
	// lookup
	// ============================================================
	// registered read, old weights on a same-edge write
	always_ff @(posedge clk) begin
		for (int i = 0; i < `BPRED_GHR_LEN; i++) begin
			lu_w[i] <= tbl[lu_idx][i];
		end
	end

	// +w for a taken history bit, -w for not taken
	always_comb begin
		psum = '0;
		for (int i = 0; i < `BPRED_GHR_LEN; i++) begin
			if (ghr[i]) begin
				psum = psum + psum_t'(lu_w[i]);
			end else begin
				psum = psum - psum_t'(lu_w[i]);
			end
		end
	end

	// zero or positive predicts taken
	assign perc_taken = ~psum[$bits(psum_t)-1];

	// ============================================================
	// training
	// ============================================================
	// agree with the outcome moves up, disagree moves down
	// ghr here is still the pre-shift history
	always_comb begin
		for (int i = 0; i < `BPRED_GHR_LEN; i++) begin
			if (update_dir == ghr[i]) begin
				if (tbl[up_idx][i] == `BPRED_WEIGHT_MAX) begin
					up_w[i] = tbl[up_idx][i];
				end else begin
					up_w[i] = tbl[up_idx][i] + 8'sd1;
				end
			end else begin
				if (tbl[up_idx][i] == `BPRED_WEIGHT_MIN) begin
					up_w[i] = tbl[up_idx][i];
				end else begin
					up_w[i] = tbl[up_idx][i] - 8'sd1;
				end
			end
		end
	end

	// read-modify-write of one entry per cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int e = 0; e < (1 << `BPRED_TBL_AW); e++) begin
				for (int i = 0; i < `BPRED_GHR_LEN; i++) begin
					tbl[e][i] <= '0;
				end
			end
		end else if (up_wen) begin
			for (int i = 0; i < `BPRED_GHR_LEN; i++) begin
				tbl[up_idx][i] <= up_w[i];
			end
		end
	end

	// execute must hand over a real pc with each resolved branch
	a_update_pc_known: assert property (@(posedge clk) disable iff (reset)
		update |-> !$isunknown(update_pc));

endmodule

//--- verilog/insn_mem.sv
`timescale 1ns/100ps
`include "bpred_params.svh"

module insn_mem (
	input	logic					clk,
	input	logic					we,
	input	bpred_pkg::imem_addr_t	waddr,
	input	bpred_pkg::insn_t		wdata,
	input	bpred_pkg::addr_t		raddr,
	output	bpred_pkg::insn_t		rdata
);
	import bpred_pkg::*;

	// word array, filled only through the write port
	insn_t		mem [0:(1 << `BPRED_IMEM_AW)-1];
	imem_addr_t	ridx;

	// word index, pc[9:2]
	assign ridx = raddr[`BPRED_IMEM_AW+1:2];

	// ============================================================
	// write port and synchronous read
	// ============================================================
	// same-address read and write returns the old word
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[ridx];
	end

	// fetch addresses never carry low bits
	a_raddr_aligned: assert property (@(posedge clk)
		!$isunknown(raddr) |-> raddr[1:0] == 2'b00);

endmodule

//--- verilog/bpred_pkg.sv
`include "bpred_params.svh"

package bpred_pkg;

	// program counter and raw instruction word
	typedef logic [`BPRED_ADDR_W-1:0]	addr_t;
	typedef logic [`BPRED_INSN_W-1:0]	insn_t;

	// word address into the insn memory
	typedef logic [`BPRED_IMEM_AW-1:0]	imem_addr_t;

	// perceptron table index and global history
	typedef logic [`BPRED_TBL_AW-1:0]	tbl_idx_t;
	// bit 0 holds the newest outcome
	typedef logic [`BPRED_GHR_LEN-1:0]	ghr_t;

	// one weight, two's complement
	typedef logic signed [`BPRED_WEIGHT_W-1:0]	weight_t;
	// dot product, 8 x 127 fits with headroom
	typedef logic signed [11:0]	psum_t;

	// stack pointer, wraps over the depth
	typedef logic [$clog2(`BPRED_RAS_DEPTH)-1:0]	ras_ptr_t;

	// predecoded target source, insn bits 31:30
	typedef enum logic [1:0] {
		src_seq		= 2'b00,
		src_ras		= 2'b01,
		src_imm16	= 2'b10,
		src_imm26	= 2'b11
	} tgt_src_t;

endpackage

//--- verilog/bpred_params.svh
`ifndef BPRED_PARAMS_SVH
`define BPRED_PARAMS_SVH

// ============================================================
// datapath widths
// ============================================================
`define BPRED_ADDR_W		32
`define BPRED_INSN_W		32
// word index into the insn memory, taken from pc[9:2]
`define BPRED_IMEM_AW		8

// ============================================================
// perceptron geometry
// ============================================================
// history bits, one weight per bit
`define BPRED_GHR_LEN		8
// table index, taken from pc[7:2]
`define BPRED_TBL_AW		6
`define BPRED_WEIGHT_W		8
// symmetric saturation, -128 never reached
`define BPRED_WEIGHT_MAX	127
`define BPRED_WEIGHT_MIN	(-127)

// return stack depth
`define BPRED_RAS_DEPTH		8

// predecode fields of an instruction word
`define BPRED_F_SRC			31:30
`define BPRED_F_UNCOND		29
`define BPRED_F_CALL		27
`define BPRED_F_IMM26		25:0
`define BPRED_F_IMM16		15:0
`define BPRED_F_IMM16_SIGN	15

`endif
